// File: src.f
+incdir+include
verilog/video_pkg.sv
verilog/bus_pkg.sv
verilog/vram_regs.sv
verilog/font_ram.sv
verilog/vga_timing.sv
verilog/color_mapper.sv
verilog/text_display_top.sv
testbench/tb_text_display.sv

// File: run_sim.sh
#!/bin/sh
# build and run the text display testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -j 0 \
	--top-module tb_text_display -o tb_text_display -f src.f
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build returned status $status"
	exit 1
fi

./obj_dir/tb_text_display > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation returned status $status"
	exit 1
fi

if grep -q "ALL CHECKS PASSED" "$LOG"; then
	exit 0
fi
exit 1

// File: testbench/tb_text_display.sv
`timescale 1ns/10ps
`include "text_display_settings.svh"

module tb_text_display import video_pkg::*; ();

	localparam int H_TOTAL = `H_ACTIVE + `H_FP + `H_SYNC + `H_BP;
	localparam int V_TOTAL = `V_ACTIVE + `V_FP + `V_SYNC + `V_BP;
	localparam int ACK_TIMEOUT = 16;
	localparam int FRAME_TIMEOUT = 2 * H_TOTAL * V_TOTAL;
	// word under test sits on text row 1
	localparam int TEST_WORD = `WORDS_PER_ROW + 1;
	localparam int CELL_X0 = (TEST_WORD % `WORDS_PER_ROW) * 4 * `GLYPH_W;
	localparam int CELL_Y0 = (TEST_WORD / `WORDS_PER_ROW) * `GLYPH_H;
	localparam int GLYPH_CODE = 65;
	localparam logic [10:0] UNMAPPED [5] = '{11'd601, 11'd700, 11'd1023, 11'd1536, 11'd2047};

	logic        clk;
	logic        arst_n;
	logic        wb_cyc;
	logic        wb_stb;
	logic        wb_we;
	logic [3:0]  wb_sel;
	logic [10:0] wb_adr;
	logic [31:0] wb_dat_w;
	logic [31:0] wb_dat_r;
	logic        wb_ack;
	chan_t       red;
	chan_t       green;
	chan_t       blue;
	logic        hsync;
	logic        vsync;
	logic        de;

	int seed;
	int err_count;
	int tests_run;
	int tests_bad;
	int test_err_base;
	bit timed_out;
	// reference model of the four cells
	logic [7:0]  glyph [`GLYPH_H];
	logic [3:0]  inv_lane;
	logic [11:0] fg_rgb;
	logic [11:0] bg_rgb;
	bit          glyph_chk;
	// raster tracker
	int   px_x;
	int   line_idx;
	int   hs_low;
	int   vs_low;
	int   vs_falls;
	int   line_checks;
	int   hs_checks;
	int   vs_checks;
	int   frame_checks;
	int   pix_checked;
	bit   frame_seen;
	logic de_q;
	logic hs_q;
	logic vs_q;

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	text_display_top u_text_display_top (
		.clk      (clk),
		.arst_n   (arst_n),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_sel   (wb_sel),
		.wb_adr   (wb_adr),
		.wb_dat_w (wb_dat_w),
		.wb_dat_r (wb_dat_r),
		.wb_ack   (wb_ack),
		.red      (red),
		.green    (green),
		.blue     (blue),
		.hsync    (hsync),
		.vsync    (vsync),
		.de       (de)
	);

	// ------------------------------------------------------------------------
	// protocol and blanking properties
	// ------------------------------------------------------------------------
	ack_single: assert property (@(posedge clk) disable iff (!arst_n) wb_ack |=> !wb_ack)
		else begin
			$display("wb_ack stayed high for more than one clock at t=%0t", $time);
			err_count++;
		end

	blank_black: assert property (@(posedge clk) disable iff (!arst_n)
		!de |-> ({red, green, blue} == 12'h000))
		else begin
			$display("mismatch t=%0t rgb expected 000 got %h%h%h", $time, red, green, blue);
			err_count++;
		end

	// no sync pulse inside the visible area
	sync_quiet: assert property (@(posedge clk) disable iff (!arst_n) de |-> (hsync && vsync))
		else begin
			$display("sync pulse during visible pixels at t=%0t", $time);
			err_count++;
		end

	task automatic timeout_abort(input string what);
		$display("timeout, %0s, at t=%0t", what, $time);
		timed_out = 1'b1;
		wait (!timed_out);
	endtask

	// ends the run when a wait gives up
	initial begin
		wait (timed_out);
		$display("CHECKS FAILED");
		$finish;
	end

	// ack polled just after each edge
	task automatic wait_ack(input logic [10:0] adr);
		bit got;
		int n;
		got = 1'b0;
		n = 0;
		while (!got && n < ACK_TIMEOUT) begin
			@(posedge clk);
			#1;
			got = wb_ack;
			n++;
		end
		if (!got)
			timeout_abort($sformatf("no ack for address %0d", adr));
	endtask

	// one idle clock between transfers
	task automatic bus_release();
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		@(posedge clk);
		#1;
	endtask

	task automatic wb_write(input logic [10:0] adr, input logic [31:0] data,
		input logic [3:0] sel);
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = 1'b1;
		wb_adr = adr;
		wb_dat_w = data;
		wb_sel = sel;
		wait_ack(adr);
		bus_release();
	endtask

	task automatic wb_read(input logic [10:0] adr, output logic [31:0] data);
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = 1'b0;
		wb_adr = adr;
		wb_sel = 4'hF;
		wait_ack(adr);
		data = wb_dat_r;
		bus_release();
	endtask

	task automatic check_word(input logic [10:0] adr, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp) else begin
			$display("mismatch t=%0t wb_dat_r at address %0d expected %h got %h",
				$time, adr, exp, got);
			err_count++;
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		assert (got === exp) else begin
			$display("mismatch t=%0t %0s expected %b got %b", $time, name, exp, got);
			err_count++;
		end
	endtask

	// old word with the selected byte lanes taken from the new one
	function automatic logic [31:0] lane_merge(input logic [31:0] old_w,
		input logic [31:0] new_w, input logic [3:0] sel);
		logic [31:0] w;
		w = old_w;
		for (int i = 0; i < 4; i++) begin
			if (sel[i])
				w[i*8 +: 8] = new_w[i*8 +: 8];
		end
		return w;
	endfunction

	// msb of a glyph row is the left pixel
	function automatic logic [11:0] cell_rgb(input int x, input int y);
		int   lane;
		logic lit;
		lane = (x - CELL_X0) / `GLYPH_W;
		lit = glyph[y - CELL_Y0][7 - (x % `GLYPH_W)] ^ inv_lane[lane];
		return lit ? fg_rgb : bg_rgb;
	endfunction

	task automatic wait_vsync_fall();
		int start;
		int n;
		start = vs_falls;
		n = 0;
		while (vs_falls == start && n < FRAME_TIMEOUT) begin
			@(posedge clk);
			#1;
			n++;
		end
		if (vs_falls == start)
			timeout_abort("no vsync falling edge");
	endtask

	// one whole frame with the new contents
	task automatic scan_cells();
		wait_vsync_fall();
		pix_checked = 0;
		glyph_chk = 1'b1;
		wait_vsync_fall();
		glyph_chk = 1'b0;
		assert (pix_checked == 4 * `GLYPH_W * `GLYPH_H) else begin
			$display("only %0d pixels of the test cells were shown", pix_checked);
			err_count++;
		end
	endtask

	task automatic end_test(input string name);
		int n;
		n = err_count - test_err_base;
		tests_run++;
		if (n != 0)
			tests_bad++;
		$display("test %0s: %0s, %0d errors", name, (n == 0) ? "ok" : "bad", n);
		test_err_base = err_count;
	endtask

	// ------------------------------------------------------------------------
	// pixel tracker, sampled mid-cycle
	// ------------------------------------------------------------------------
	always @(negedge clk) begin
		if (!arst_n) begin
			px_x = 0;
			line_idx = 0;
			hs_low = 0;
			vs_low = 0;
			vs_falls = 0;
			line_checks = 0;
			hs_checks = 0;
			vs_checks = 0;
			frame_checks = 0;
			frame_seen = 1'b0;
			de_q = 1'b0;
			hs_q = 1'b1;
			vs_q = 1'b1;
		end else begin
			if (de) begin
				if (glyph_chk && frame_seen && px_x >= CELL_X0 && px_x < CELL_X0 + 32
					&& line_idx >= CELL_Y0 && line_idx < CELL_Y0 + `GLYPH_H) begin
					pix_checked++;
					assert ({red, green, blue} === cell_rgb(px_x, line_idx)) else begin
						$display("mismatch t=%0t rgb at (%0d,%0d) expected %h got %h%h%h",
							$time, px_x, line_idx, cell_rgb(px_x, line_idx), red, green, blue);
						err_count++;
					end
				end
				px_x++;
			end else if (de_q) begin
				// end of a visible line
				assert (px_x == `H_ACTIVE) else begin
					$display("mismatch t=%0t de clocks per line expected %0d got %0d",
						$time, `H_ACTIVE, px_x);
					err_count++;
				end
				line_checks++;
				px_x = 0;
				line_idx++;
			end
			if (!hsync) begin
				hs_low++;
			end else if (!hs_q) begin
				assert (hs_low == `H_SYNC) else begin
					$display("mismatch t=%0t hsync low clocks expected %0d got %0d",
						$time, `H_SYNC, hs_low);
					err_count++;
				end
				hs_checks++;
				hs_low = 0;
			end
			if (!vsync) begin
				vs_low++;
			end else if (!vs_q) begin
				assert (vs_low == `V_SYNC * H_TOTAL) else begin
					$display("mismatch t=%0t vsync low clocks expected %0d got %0d",
						$time, `V_SYNC * H_TOTAL, vs_low);
					err_count++;
				end
				vs_checks++;
				vs_low = 0;
			end
			// frame boundary
			if (!vsync && vs_q) begin
				if (frame_seen) begin
					assert (line_idx == `V_ACTIVE) else begin
						$display("mismatch t=%0t active lines expected %0d got %0d",
							$time, `V_ACTIVE, line_idx);
						err_count++;
					end
					frame_checks++;
				end
				frame_seen = 1'b1;
				line_idx = 0;
				vs_falls++;
			end
			de_q = de;
			hs_q = hsync;
			vs_q = vsync;
		end
	end

	// ------------------------------------------------------------------------
	// test sequence
	// ------------------------------------------------------------------------
	initial begin
		logic [31:0] old_w;
		logic [31:0] new_w;
		logic [31:0] got_w;
		logic [3:0]  sel;
		logic [10:0] adr;
		logic [11:0] color;
		seed = 3;
		err_count = 0;
		tests_run = 0;
		tests_bad = 0;
		test_err_base = 0;
		timed_out = 1'b0;
		glyph_chk = 1'b0;
		pix_checked = 0;
		inv_lane = 4'h0;
		fg_rgb = '0;
		bg_rgb = '0;
		arst_n = 1'b0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_sel = 4'h0;
		wb_adr = '0;
		wb_dat_w = '0;
		repeat (3) @(posedge clk);
		#1;
		arst_n = 1'b1;

		// idle outputs before any bus traffic
		check_bit("wb_ack", wb_ack, 1'b0);
		check_bit("de", de, 1'b0);
		check_bit("hsync", hsync, 1'b1);
		check_bit("vsync", vsync, 1'b1);
		repeat (8) @(posedge clk);
		#1;
		end_test("reset");

		// character, control, then font region
		for (int r = 0; r < 3; r++) begin
			for (int i = 0; i < 6; i++) begin
				case (r)
					0: adr = 11'({$random(seed)} % `VRAM_WORDS);
					1: adr = 11'(`CTRL_ADDR);
					default: adr = 11'(`FONT_BASE + {$random(seed)} % `FONT_WORDS);
				endcase
				old_w = $random(seed);
				new_w = $random(seed);
				sel = 4'($random(seed));
				wb_write(adr, old_w, 4'hF);
				wb_write(adr, new_w, sel);
				wb_read(adr, got_w);
				check_word(adr, got_w, lane_merge(old_w, new_w, sel));
			end
		end
		for (int i = 0; i < 5; i++) begin
			wb_write(UNMAPPED[i], $random(seed), 4'hF);
			wb_read(UNMAPPED[i], got_w);
			check_word(UNMAPPED[i], got_w, 32'h0);
		end
		end_test("readback");

		// tracker checks widths on its own, one full frame
		wait_vsync_fall();
		wait_vsync_fall();
		assert (frame_checks > 0 && vs_checks > 0 && line_checks >= `V_ACTIVE
			&& hs_checks >= V_TOTAL) else begin
			$display("raster edges were not seen for a whole frame");
			err_count++;
		end
		end_test("raster");

		// glyph rows, byte n of font word w is row 4w+n
		for (int r = 0; r < `GLYPH_H; r++)
			glyph[r] = 8'($random(seed));
		for (int w = 0; w < 4; w++) begin
			wb_write(11'(`FONT_BASE + GLYPH_CODE * 4 + w),
				{glyph[4*w+3], glyph[4*w+2], glyph[4*w+1], glyph[4*w]}, 4'hF);
		end
		color = 12'($random(seed));
		fg_rgb = color;
		bg_rgb = ~color;
		wb_write(11'(`CTRL_ADDR), {8'h00, fg_rgb, bg_rgb}, 4'hF);
		inv_lane = 4'b0000;
		wb_write(11'(TEST_WORD), {4{8'(GLYPH_CODE)}}, 4'hF);
		scan_cells();
		end_test("glyph");

		// lane 2 only, invert bit set
		inv_lane = 4'b0100;
		wb_write(11'(TEST_WORD), {8'h00, 8'h80 | 8'(GLYPH_CODE), 16'h0000}, 4'b0100);
		wb_read(11'(TEST_WORD), got_w);
		check_word(11'(TEST_WORD), got_w,
			{8'(GLYPH_CODE), 8'h80 | 8'(GLYPH_CODE), 8'(GLYPH_CODE), 8'(GLYPH_CODE)});
		scan_cells();
		end_test("invert");

		$display("tests %0d, tests with errors %0d, errors %0d",
			tests_run, tests_bad, err_count);
		if (err_count == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

// File: verilog/text_display_top.sv
`timescale 1ns/10ps
`include "text_display_settings.svh"

module text_display_top import video_pkg::*, bus_pkg::*; (
	input  logic        clk,
	input  logic        arst_n,
	input  logic        wb_cyc,
	input  logic        wb_stb,
	input  logic        wb_we,
	input  logic [3:0]  wb_sel,
	input  logic [10:0] wb_adr,
	input  logic [31:0] wb_dat_w,
	output logic [31:0] wb_dat_r,
	output logic        wb_ack,
	output chan_t       red,
	output chan_t       green,
	output chan_t       blue,
	output logic        hsync,
	output logic        vsync,
	output logic        de
);

	wb_region_e  wb_region;
	logic        bus_req;
	logic        vram_stb;
	logic        font_stb;
	logic        vram_ack;
	logic        font_ack;
	logic [31:0] vram_dat_r;
	logic [31:0] font_dat_r;
	// raster to mapper
	coord_t      draw_x;
	coord_t      draw_y;
	logic        raw_de;
	logic        raw_hsync;
	logic        raw_vsync;
	// mapper read ports
	logic [9:0]  vram_rd_addr;
	logic [31:0] vram_rd_data;
	logic [23:0] ctrl_word;
	logic [10:0] font_rd_addr;
	logic [7:0]  font_rd_data;

	// ------------------------------------------------------------------------
	// bus decode
	// ------------------------------------------------------------------------
	always_comb begin
		if (wb_adr < `WB_ADR_W'(`VRAM_WORDS))
			wb_region = REG_VRAM;
		else if (wb_adr == `WB_ADR_W'(`CTRL_ADDR))
			wb_region = REG_CTRL;
		else if (wb_adr >= `WB_ADR_W'(`FONT_BASE)
			&& wb_adr < `WB_ADR_W'(`FONT_BASE + `FONT_WORDS))
			wb_region = REG_FONT;
		else
			wb_region = REG_NONE;
	end

	assign bus_req = wb_cyc && wb_stb;
	// unmapped addresses go to the register block
	assign vram_stb = bus_req && (wb_region != REG_FONT);
	assign font_stb = bus_req && (wb_region == REG_FONT);
	assign wb_ack = vram_ack | font_ack;
	// master holds adr until ack, so the live region steers data
	assign wb_dat_r = (wb_region == REG_FONT) ? font_dat_r : vram_dat_r;

	vram_regs u_vram_regs (
		.clk          (clk),
		.arst_n       (arst_n),
		.stb          (vram_stb),
		.we           (wb_we),
		.sel          (wb_sel),
		.adr          (wb_adr),
		.dat_w        (wb_dat_w),
		.dat_r        (vram_dat_r),
		.ack          (vram_ack),
		.vram_rd_addr (vram_rd_addr),
		.vram_rd_data (vram_rd_data),
		.ctrl_word    (ctrl_word)
	);

	// font base is 512-aligned, low 9 bits index the words
	font_ram u_font_ram (
		.clk          (clk),
		.arst_n       (arst_n),
		.stb          (font_stb),
		.we           (wb_we),
		.sel          (wb_sel),
		.adr          (wb_adr[8:0]),
		.dat_w        (wb_dat_w),
		.dat_r        (font_dat_r),
		.ack          (font_ack),
		.font_rd_addr (font_rd_addr),
		.font_rd_data (font_rd_data)
	);

	// ------------------------------------------------------------------------
	// video path
	// ------------------------------------------------------------------------
	vga_timing u_vga_timing (
		.clk    (clk),
		.arst_n (arst_n),
		.draw_x (draw_x),
		.draw_y (draw_y),
		.de     (raw_de),
		.hsync  (raw_hsync),
		.vsync  (raw_vsync)
	);

	color_mapper u_color_mapper (
		.clk          (clk),
		.arst_n       (arst_n),
		.draw_x       (draw_x),
		.draw_y       (draw_y),
		.de_in        (raw_de),
		.hsync_in     (raw_hsync),
		.vsync_in     (raw_vsync),
		.vram_rd_addr (vram_rd_addr),
		.vram_rd_data (vram_rd_data),
		.ctrl_word    (ctrl_word),
		.font_rd_addr (font_rd_addr),
		.font_rd_data (font_rd_data),
		.red          (red),
		.green        (green),
		.blue         (blue),
		.de           (de),
		.hsync        (hsync),
		.vsync        (vsync)
	);

endmodule

// File: verilog/color_mapper.sv
`timescale 1ns/10ps
`include "text_display_settings.svh"

module color_mapper import video_pkg::*; (
	input  logic        clk,
	input  logic        arst_n,
	input  coord_t      draw_x,
	input  coord_t      draw_y,
	input  logic        de_in,
	input  logic        hsync_in,
	input  logic        vsync_in,
	output logic [9:0]  vram_rd_addr,
	input  logic [31:0] vram_rd_data,
	input  logic [23:0] ctrl_word,
	output logic [10:0] font_rd_addr,
	input  logic [7:0]  font_rd_data,
	output chan_t       red,
	output chan_t       green,
	output chan_t       blue,
	output logic        de,
	output logic        hsync,
	output logic        vsync
);

	// sync and enable delay lines, last stage is the output
	logic [`PIPE_DEPTH-1:0] de_sr;
	logic [`PIPE_DEPTH-1:0] hs_sr;
	logic [`PIPE_DEPTH-1:0] vs_sr;
	// stage 1 payload
	logic [1:0]  s1_byte;
	logic [2:0]  s1_px;
	logic [3:0]  s1_row;
	// stage 2 payload
	logic [7:0]  char_byte;
	logic        s2_invert;
	logic [2:0]  s2_px;
	// stage 3 select
	logic        glyph_bit;
	logic        use_fg;

	// ------------------------------------------------------------------------
	// stage 1, word index from the text cell
	// ------------------------------------------------------------------------
	// row/16*20 + col/32, memory answers next clock
	assign vram_rd_addr = 10'((draw_y / `GLYPH_H) * `WORDS_PER_ROW
		+ draw_x / (4 * `GLYPH_W));

	always_ff @(posedge clk) begin
		s1_byte <= draw_x[4:3];
		s1_px <= draw_x[2:0];
		s1_row <= draw_y[3:0];
	end

	// ------------------------------------------------------------------------
	// stage 2, byte select and font address
	// ------------------------------------------------------------------------
	assign char_byte = vram_rd_data[{s1_byte, 3'b000} +: 8];
	// code*16 + glyph row
	assign font_rd_addr = {char_byte[6:0], s1_row};

	always_ff @(posedge clk) begin
		s2_invert <= char_byte[7];
		s2_px <= s1_px;
	end

	// ------------------------------------------------------------------------
	// stage 3, glyph bit to color
	// ------------------------------------------------------------------------
	// msb of the font byte is the leftmost pixel
	assign glyph_bit = font_rd_data[3'd7 - s2_px];
	assign use_fg = glyph_bit ^ s2_invert;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			red <= '0;
			green <= '0;
			blue <= '0;
		end else if (!de_sr[`PIPE_DEPTH-2]) begin
			// black outside the visible area
			red <= '0;
			green <= '0;
			blue <= '0;
		end else if (use_fg) begin
			red <= ctrl_word[23:20];
			green <= ctrl_word[19:16];
			blue <= ctrl_word[15:12];
		end else begin
			red <= ctrl_word[11:8];
			green <= ctrl_word[7:4];
			blue <= ctrl_word[3:0];
		end
	end

	// syncs idle high, enable idle low
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			de_sr <= '0;
			hs_sr <= '1;
			vs_sr <= '1;
		end else begin
			de_sr <= {de_sr[`PIPE_DEPTH-2:0], de_in};
			hs_sr <= {hs_sr[`PIPE_DEPTH-2:0], hsync_in};
			vs_sr <= {vs_sr[`PIPE_DEPTH-2:0], vsync_in};
		end
	end

	assign de = de_sr[`PIPE_DEPTH-1];
	assign hsync = hs_sr[`PIPE_DEPTH-1];
	assign vsync = vs_sr[`PIPE_DEPTH-1];

endmodule

// File: verilog/vga_timing.sv
`timescale 1ns/10ps
`include "text_display_settings.svh"

module vga_timing import video_pkg::*; (
	input  logic   clk,
	input  logic   arst_n,
	output coord_t draw_x,
	output coord_t draw_y,
	output logic   de,
	output logic   hsync,
	output logic   vsync
);

	localparam int H_TOTAL = `H_ACTIVE + `H_FP + `H_SYNC + `H_BP;
	localparam int V_TOTAL = `V_ACTIVE + `V_FP + `V_SYNC + `V_BP;
	localparam coord_t H_LAST = coord_t'(H_TOTAL - 1);
	localparam coord_t V_LAST = coord_t'(V_TOTAL - 1);

	coord_t        h_cnt;
	coord_t        v_cnt;
	raster_phase_e h_phase;
	raster_phase_e v_phase;

	// phase from a counter and the widths of its first three regions
	function automatic raster_phase_e phase_of(coord_t c, int act, int fp, int sw);
		raster_phase_e p;
		if (c < act)
			p = ACTIVE;
		else if (c < act + fp)
			p = FRONT;
		else if (c < act + fp + sw)
			p = SYNC;
		else
			p = BACK;
		return p;
	endfunction

	// ------------------------------------------------------------------------
	// counters
	// ------------------------------------------------------------------------
	// start at the top of vertical blanking
	// first full frame begins after one vsync
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			h_cnt <= '0;
			v_cnt <= coord_t'(`V_ACTIVE);
		end else if (h_cnt == H_LAST) begin
			h_cnt <= '0;
			v_cnt <= (v_cnt == V_LAST) ? '0 : v_cnt + 1'b1;
		end else begin
			h_cnt <= h_cnt + 1'b1;
		end
	end

	assign h_phase = phase_of(h_cnt, `H_ACTIVE, `H_FP, `H_SYNC);
	assign v_phase = phase_of(v_cnt, `V_ACTIVE, `V_FP, `V_SYNC);

	// outputs, syncs active low
	assign draw_x = h_cnt;
	assign draw_y = v_cnt;
	assign de = (h_phase == ACTIVE) && (v_phase == ACTIVE);
	assign hsync = (h_phase != SYNC);
	assign vsync = (v_phase != SYNC);

	counters_in_range: assert property (@(posedge clk) disable iff (!arst_n)
		(h_cnt < H_TOTAL) && (v_cnt < V_TOTAL));

endmodule

// File: verilog/font_ram.sv
`timescale 1ns/10ps
`include "text_display_settings.svh"

module font_ram import bus_pkg::*; (
	input  logic        clk,
	input  logic        arst_n,
	input  logic        stb,
	input  logic        we,
	input  logic [3:0]  sel,
	input  logic [8:0]  adr,
	input  logic [31:0] dat_w,
	output logic [31:0] dat_r,
	output logic        ack,
	input  logic [10:0] font_rd_addr,
	output logic [7:0]  font_rd_data
);

	// byte n of word w is glyph byte 4w+n
	logic [31:0] font_mem [`FONT_WORDS];
	logic [31:0] rd_word;
	wb_state_e   state;
	logic        take;

	assign take = (state == IDLE) && stb;
	assign ack = (state == ACK);
	assign rd_word = font_mem[font_rd_addr[10:2]];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= IDLE;
		end else begin
			state <= take ? ACK : IDLE;
		end
	end

	always_ff @(posedge clk) begin
		if (take && we) begin
			for (int i = 0; i < 4; i++) begin
				if (sel[i])
					font_mem[adr][i*8 +: 8] <= dat_w[i*8 +: 8];
			end
		end
		if (take)
			dat_r <= font_mem[adr];
		// mapper port, low address bits pick the lane
		font_rd_data <= rd_word[{font_rd_addr[1:0], 3'b000} +: 8];
	end

	// ack is a single clock pulse even with stb held
	ack_one_clock: assert property (@(posedge clk) disable iff (!arst_n)
		ack |=> !ack);

endmodule

// File: verilog/vram_regs.sv
`timescale 1ns/10ps
`include "text_display_settings.svh"

module vram_regs import bus_pkg::*; (
	input  logic        clk,
	input  logic        arst_n,
	input  logic        stb,
	input  logic        we,
	input  logic [3:0]  sel,
	input  logic [10:0] adr,
	input  logic [31:0] dat_w,
	output logic [31:0] dat_r,
	output logic        ack,
	input  logic [9:0]  vram_rd_addr,
	output logic [31:0] vram_rd_data,
	output logic [23:0] ctrl_word
);

	// character words, byte k is column 4w+k
	logic [31:0] vram [`VRAM_WORDS];
	// full word kept so readback matches all lanes
	logic [31:0] ctrl_q;
	wb_state_e   state;
	logic        hit_vram;
	logic        hit_ctrl;
	logic        take;

	assign hit_vram = adr < 11'(`VRAM_WORDS);
	assign hit_ctrl = adr == 11'(`CTRL_ADDR);
	// one request taken per idle clock
	assign take = (state == IDLE) && stb;
	assign ack = (state == ACK);
	// fg in 23:12, bg in 11:0
	assign ctrl_word = ctrl_q[23:0];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= IDLE;
		end else begin
			state <= take ? ACK : IDLE;
		end
	end

	// control word, lane writes
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ctrl_q <= '0;
		end else if (take && we && hit_ctrl) begin
			for (int i = 0; i < 4; i++) begin
				if (sel[i])
					ctrl_q[i*8 +: 8] <= dat_w[i*8 +: 8];
			end
		end
	end

	// ------------------------------------------------------------------------
	// character memory, bus port plus mapper read port
	// ------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (take && we && hit_vram) begin
			for (int i = 0; i < 4; i++) begin
				if (sel[i])
					vram[adr[9:0]][i*8 +: 8] <= dat_w[i*8 +: 8];
			end
		end
		// blanking positions land past the end, show blank
		if (vram_rd_addr < 10'(`VRAM_WORDS))
			vram_rd_data <= vram[vram_rd_addr];
		else
			vram_rd_data <= '0;
	end

	// bus read data, valid with ack
	always_ff @(posedge clk) begin
		if (take) begin
			if (hit_vram)
				dat_r <= vram[adr[9:0]];
			else if (hit_ctrl)
				dat_r <= ctrl_q;
			else
				dat_r <= '0;
		end
	end

	// no ack without a request on the clock before
	ack_after_stb: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(ack) |-> $past(stb));

endmodule

// File: verilog/bus_pkg.sv
package bus_pkg;

	// slave handshake, ack held for one clock
	typedef enum logic {
		IDLE,
		ACK
	} wb_state_e;

	// decoded target of a word address
	typedef enum logic [1:0] {
		// character words
		REG_VRAM,
		// color control word
		REG_CTRL,
		// glyph bytes
		REG_FONT,
		// unmapped, acks and reads zero
		REG_NONE
	} wb_region_e;

endpackage

// File: verilog/video_pkg.sv
package video_pkg;

	// --------------------------------------------------------------------------
	// raster types
	// --------------------------------------------------------------------------

	// phase inside one line or one frame
	typedef enum logic [1:0] {
		ACTIVE,
		FRONT,
		SYNC,
		BACK
	} raster_phase_e;

	// pixel coordinate, wide enough for the blanking region too
	typedef logic [9:0] coord_t;

	// --------------------------------------------------------------------------
	// color types
	// --------------------------------------------------------------------------

	// one channel, 4 bits per color
	typedef logic [3:0] chan_t;

endpackage

// File: include/text_display_settings.svh
`ifndef TEXT_DISPLAY_SETTINGS_SVH
`define TEXT_DISPLAY_SETTINGS_SVH

// horizontal raster, in pixel clocks
`define H_ACTIVE 640
`define H_FP 16
`define H_SYNC 96
`define H_BP 48

// vertical raster, in lines
`define V_ACTIVE 480
`define V_FP 10
`define V_SYNC 2
`define V_BP 33

// text geometry
`define TEXT_COLS 80
`define TEXT_ROWS 30
`define GLYPH_W 8
`define GLYPH_H 16

// character memory, four glyphs per word
`define WORDS_PER_ROW 20
`define VRAM_WORDS 600

// word address map
`define CTRL_ADDR 600
`define FONT_BASE 1024
`define FONT_WORDS 512
`define WB_ADR_W 11

// pixel path latency
`define PIPE_DEPTH 3

`endif
